//--- design/cpuPkg.sv
package cpuPkg;

    // Datapath and memory sizes
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int memWords     = 64;
    localparam int memAddrWidth = 6;

    // Opcodes
    localparam logic [5:0] opRType = 6'b00_0000;
    localparam logic [5:0] opAddi  = 6'b00_1000;
    localparam logic [5:0] opLw    = 6'b10_0011;
    localparam logic [5:0] opSw    = 6'b10_1011;
    localparam logic [5:0] opBeq   = 6'b00_0100;

    // R-type funct field
    localparam logic [5:0] fnAdd = 6'b10_0000;
    localparam logic [5:0] fnSub = 6'b10_0010;
    localparam logic [5:0] fnAnd = 6'b10_0100;
    localparam logic [5:0] fnOr  = 6'b10_0101;
    localparam logic [5:0] fnSlt = 6'b10_1010;

    // ALU operations
    localparam int aluOpWidth = 3;
    localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 3'd3;
    localparam logic [aluOpWidth-1:0] aluSlt = 3'd4;

    // One instruction word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } r;
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0]             imm;
        } i;
    } instrT;

endpackage

//--- design/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import cpuPkg::*;
(
    input  logic                    clock,
    input  logic                    i_rstN,
    input  logic                    i_run,
    input  logic                    i_imemWe,
    input  logic [memAddrWidth-1:0] i_imemAddr,
    input  logic [dataWidth-1:0]    i_imemData,
    input  logic                    i_stall,
    input  logic                    i_branchTaken,
    input  logic [dataWidth-1:0]    i_branchTarget,
    output instrT                   o_instr,
    output logic [dataWidth-1:0]    o_pcPlus4
);

    logic [dataWidth-1:0] imem [memWords];
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;

    assign pcPlus4 = pc + 32'd4;

    // Word-wide load port
    always_ff @(posedge clock)
    begin
        if (i_imemWe)
            imem[i_imemAddr] <= i_imemData;
    end

    // Program counter
    always_ff @(posedge clock)
    begin
        if (!i_rstN || !i_run)
            pc <= '0;
        else if (i_branchTaken)
            pc <= i_branchTarget;
        else if (!i_stall)
            pc <= pcPlus4;
    end

    // IF/ID register, squashed to a no-op on a taken branch
    always_ff @(posedge clock)
    begin
        if (!i_rstN || !i_run || i_branchTaken)
            o_instr <= '0;
        else if (!i_stall)
            o_instr <= imem[pc[memAddrWidth+1:2]];

        if (!i_stall)
            o_pcPlus4 <= pcPlus4;
    end

endmodule

//--- design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*;
(
    input  logic                    clock,
    input  logic                    i_rstN,
    input  instrT                   i_instr,
    input  logic [dataWidth-1:0]    i_pcPlus4,
    input  logic                    i_branchTaken,
    input  logic                    i_wbWrite,
    input  logic [regAddrWidth-1:0] i_wbReg,
    input  logic [dataWidth-1:0]    i_wbData,
    output logic                    o_stall,
    output logic                    o_regWrite,
    output logic                    o_memToReg,
    output logic                    o_memWrite,
    output logic                    o_branch,
    output logic                    o_aluSrc,
    output logic [aluOpWidth-1:0]   o_aluOp,
    output logic [dataWidth-1:0]    o_srcA,
    output logic [dataWidth-1:0]    o_srcB,
    output logic [regAddrWidth-1:0] o_rs,
    output logic [regAddrWidth-1:0] o_rt,
    output logic [regAddrWidth-1:0] o_writeReg,
    output logic [dataWidth-1:0]    o_imm,
    output logic [dataWidth-1:0]    o_pcPlus4
);

    logic [dataWidth-1:0] regFile [2**regAddrWidth];

    logic                  decRegWrite;
    logic                  decMemToReg;
    logic                  decMemWrite;
    logic                  decBranch;
    logic                  decAluSrc;
    logic                  decRegDst;
    logic [aluOpWidth-1:0] decAluOp;
    logic [dataWidth-1:0]  readA;
    logic [dataWidth-1:0]  readB;

    // Register read with write-through, r0 is hardwired to zero
    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] idx);
        logic [dataWidth-1:0] value;
        if (idx == '0)
            value = '0;
        else if (i_wbWrite && i_wbReg == idx)
            value = i_wbData;
        else
            value = regFile[idx];
        return value;
    endfunction

    // Control decode, anything unknown stays a no-op
    always_comb
    begin
        decRegWrite = 1'b0;
        decMemToReg = 1'b0;
        decMemWrite = 1'b0;
        decBranch   = 1'b0;
        decAluSrc   = 1'b1;
        decRegDst   = 1'b0;
        decAluOp    = aluAdd;
        case (i_instr.r.opcode)
            opRType:
            begin
                decAluSrc = 1'b0;
                decRegDst = 1'b1;
                decRegWrite = 1'b1;
                case (i_instr.r.funct)
                    fnAdd: decAluOp = aluAdd;
                    fnSub: decAluOp = aluSub;
                    fnAnd: decAluOp = aluAnd;
                    fnOr:  decAluOp = aluOr;
                    fnSlt: decAluOp = aluSlt;
                    default: decRegWrite = 1'b0;
                endcase
            end
            opAddi: decRegWrite = 1'b1;
            opLw:
            begin
                decRegWrite = 1'b1;
                decMemToReg = 1'b1;
            end
            opSw: decMemWrite = 1'b1;
            opBeq:
            begin
                decAluSrc = 1'b0;
                decAluOp  = aluSub;
                decBranch = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb
    begin
        readA = readReg(i_instr.r.rs);
        readB = readReg(i_instr.r.rt);
    end

    // Load in execute feeding the instruction in decode
    assign o_stall = o_memToReg && (o_rt == i_instr.r.rs || o_rt == i_instr.r.rt);

    always_ff @(posedge clock)
    begin
        if (!i_rstN)
        begin
            for (int k = 0; k < 2**regAddrWidth; k++)
                regFile[k] <= '0;
        end
        else if (i_wbWrite)
            regFile[i_wbReg] <= i_wbData;
    end

    // ID/EX register, a bubble on stall or taken branch
    always_ff @(posedge clock)
    begin
        if (!i_rstN || o_stall || i_branchTaken)
        begin
            o_regWrite <= 1'b0;
            o_memToReg <= 1'b0;
            o_memWrite <= 1'b0;
            o_branch   <= 1'b0;
        end
        else
        begin
            o_regWrite <= decRegWrite;
            o_memToReg <= decMemToReg;
            o_memWrite <= decMemWrite;
            o_branch   <= decBranch;
        end
        o_aluSrc   <= decAluSrc;
        o_aluOp    <= decAluOp;
        o_srcA     <= readA;
        o_srcB     <= readB;
        o_rs       <= i_instr.r.rs;
        o_rt       <= i_instr.r.rt;
        o_writeReg <= decRegDst ? i_instr.r.rd : i_instr.r.rt;
        o_imm      <= {{(dataWidth-16){i_instr.i.imm[15]}}, i_instr.i.imm};
        o_pcPlus4  <= i_pcPlus4;
    end

endmodule

//--- design/executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*;
(
    input  logic                    clock,
    input  logic                    i_rstN,
    input  logic                    i_regWrite,
    input  logic                    i_memToReg,
    input  logic                    i_memWrite,
    input  logic                    i_branch,
    input  logic                    i_aluSrc,
    input  logic [aluOpWidth-1:0]   i_aluOp,
    input  logic [dataWidth-1:0]    i_srcA,
    input  logic [dataWidth-1:0]    i_srcB,
    input  logic [regAddrWidth-1:0] i_rs,
    input  logic [regAddrWidth-1:0] i_rt,
    input  logic [regAddrWidth-1:0] i_writeReg,
    input  logic [dataWidth-1:0]    i_imm,
    input  logic [dataWidth-1:0]    i_pcPlus4,
    input  logic                    i_branchTaken,
    input  logic                    i_memRegWrite,
    input  logic [regAddrWidth-1:0] i_memWriteReg,
    input  logic [dataWidth-1:0]    i_memAluOut,
    input  logic                    i_wbWrite,
    input  logic [regAddrWidth-1:0] i_wbReg,
    input  logic [dataWidth-1:0]    i_wbData,
    output logic                    o_regWrite,
    output logic                    o_memToReg,
    output logic                    o_memWrite,
    output logic                    o_branch,
    output logic                    o_zero,
    output logic [dataWidth-1:0]    o_aluOut,
    output logic [dataWidth-1:0]    o_storeData,
    output logic [regAddrWidth-1:0] o_writeReg,
    output logic [dataWidth-1:0]    o_branchTarget
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] fwdB;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;

    // MEM result wins over WB result
    function automatic logic [dataWidth-1:0] forward(
        input logic [regAddrWidth-1:0] idx,
        input logic [dataWidth-1:0]    regValue
    );
        logic [dataWidth-1:0] value;
        if (i_memRegWrite && i_memWriteReg != '0 && i_memWriteReg == idx)
            value = i_memAluOut;
        else if (i_wbWrite && i_wbReg == idx)
            value = i_wbData;
        else
            value = regValue;
        return value;
    endfunction

    always_comb
    begin
        opA  = forward(i_rs, i_srcA);
        fwdB = forward(i_rt, i_srcB);
        opB  = i_aluSrc ? i_imm : fwdB;
    end

    always_comb
    begin
        case (i_aluOp)
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            // Signed compare
            aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clock)
    begin
        if (!i_rstN || i_branchTaken)
        begin
            o_regWrite <= 1'b0;
            o_memToReg <= 1'b0;
            o_memWrite <= 1'b0;
            o_branch   <= 1'b0;
        end
        else
        begin
            o_regWrite <= i_regWrite;
            o_memToReg <= i_memToReg;
            o_memWrite <= i_memWrite;
            o_branch   <= i_branch;
        end
        o_zero         <= (aluResult == '0);
        o_aluOut       <= aluResult;
        o_storeData    <= fwdB;
        o_writeReg     <= i_writeReg;
        o_branchTarget <= i_pcPlus4 + (i_imm << 2);
    end

endmodule

//--- design/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import cpuPkg::*;
(
    input  logic                    clock,
    input  logic                    i_rstN,
    input  logic                    i_regWrite,
    input  logic                    i_memToReg,
    input  logic                    i_memWrite,
    input  logic                    i_branch,
    input  logic                    i_zero,
    input  logic [dataWidth-1:0]    i_aluOut,
    input  logic [dataWidth-1:0]    i_storeData,
    input  logic [regAddrWidth-1:0] i_writeReg,
    input  logic [dataWidth-1:0]    i_branchTarget,
    output logic                    o_branchTaken,
    output logic [dataWidth-1:0]    o_branchTarget,
    output logic                    o_memRegWrite,
    output logic [regAddrWidth-1:0] o_memWriteReg,
    output logic [dataWidth-1:0]    o_memAluOut,
    output logic                    o_wbWrite,
    output logic [regAddrWidth-1:0] o_wbReg,
    output logic [dataWidth-1:0]    o_wbData,
    output logic                    o_storeValid,
    output logic [dataWidth-1:0]    o_storeAddr,
    output logic [dataWidth-1:0]    o_storeData
);

    logic [dataWidth-1:0] dmem [memWords];

    logic                    wbRegWrite;
    logic                    wbMemToReg;
    logic [dataWidth-1:0]    wbAluOut;
    logic [dataWidth-1:0]    wbReadData;
    logic [memAddrWidth-1:0] wordAddr;

    assign wordAddr = i_aluOut[memAddrWidth+1:2];

    // beq taken when the operands compared equal
    assign o_branchTaken  = i_branch && i_zero;
    assign o_branchTarget = i_branchTarget;

    assign o_memRegWrite = i_regWrite;
    assign o_memWriteReg = i_writeReg;
    assign o_memAluOut   = i_aluOut;

    assign o_storeValid = i_memWrite;
    assign o_storeAddr  = i_aluOut;
    assign o_storeData  = i_storeData;

    always_ff @(posedge clock)
    begin
        if (i_memWrite)
            dmem[wordAddr] <= i_storeData;
    end

    // MEM/WB register
    always_ff @(posedge clock)
    begin
        if (!i_rstN)
            wbRegWrite <= 1'b0;
        else
            wbRegWrite <= i_regWrite;
        wbMemToReg <= i_memToReg;
        wbAluOut   <= i_aluOut;
        wbReadData <= dmem[wordAddr];
        o_wbReg    <= i_writeReg;
    end

    // Writes to r0 are dropped here
    assign o_wbWrite = wbRegWrite && o_wbReg != '0;
    assign o_wbData  = wbMemToReg ? wbReadData : wbAluOut;

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*;
(
    input  logic                    clock,
    input  logic                    i_rstN,
    input  logic                    i_run,
    input  logic                    i_imemWe,
    input  logic [memAddrWidth-1:0] i_imemAddr,
    input  logic [dataWidth-1:0]    i_imemData,
    output logic                    o_wbValid,
    output logic [regAddrWidth-1:0] o_wbReg,
    output logic [dataWidth-1:0]    o_wbData,
    output logic                    o_storeValid,
    output logic [dataWidth-1:0]    o_storeAddr,
    output logic [dataWidth-1:0]    o_storeData
);

    // IF/ID
    instrT                   ifInstr;
    logic [dataWidth-1:0]    ifPcPlus4;
    logic                    stall;

    // ID/EX
    logic                    idRegWrite;
    logic                    idMemToReg;
    logic                    idMemWrite;
    logic                    idBranch;
    logic                    idAluSrc;
    logic [aluOpWidth-1:0]   idAluOp;
    logic [dataWidth-1:0]    idSrcA;
    logic [dataWidth-1:0]    idSrcB;
    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [regAddrWidth-1:0] idWriteReg;
    logic [dataWidth-1:0]    idImm;
    logic [dataWidth-1:0]    idPcPlus4;

    // EX/MEM
    logic                    exRegWrite;
    logic                    exMemToReg;
    logic                    exMemWrite;
    logic                    exBranch;
    logic                    exZero;
    logic [dataWidth-1:0]    exAluOut;
    logic [dataWidth-1:0]    exStoreData;
    logic [regAddrWidth-1:0] exWriteReg;
    logic [dataWidth-1:0]    exBranchTarget;

    // Feedback from memory stage
    logic                    branchTaken;
    logic [dataWidth-1:0]    branchTarget;
    logic                    memRegWrite;
    logic [regAddrWidth-1:0] memWriteReg;
    logic [dataWidth-1:0]    memAluOut;

    fetchStage u_fetch (
        .clock          (clock),
        .i_rstN         (i_rstN),
        .i_run          (i_run),
        .i_imemWe       (i_imemWe),
        .i_imemAddr     (i_imemAddr),
        .i_imemData     (i_imemData),
        .i_stall        (stall),
        .i_branchTaken  (branchTaken),
        .i_branchTarget (branchTarget),
        .o_instr        (ifInstr),
        .o_pcPlus4      (ifPcPlus4)
    );

    decodeStage u_decode (
        .clock         (clock),
        .i_rstN        (i_rstN),
        .i_instr       (ifInstr),
        .i_pcPlus4     (ifPcPlus4),
        .i_branchTaken (branchTaken),
        .i_wbWrite     (o_wbValid),
        .i_wbReg       (o_wbReg),
        .i_wbData      (o_wbData),
        .o_stall       (stall),
        .o_regWrite    (idRegWrite),
        .o_memToReg    (idMemToReg),
        .o_memWrite    (idMemWrite),
        .o_branch      (idBranch),
        .o_aluSrc      (idAluSrc),
        .o_aluOp       (idAluOp),
        .o_srcA        (idSrcA),
        .o_srcB        (idSrcB),
        .o_rs          (idRs),
        .o_rt          (idRt),
        .o_writeReg    (idWriteReg),
        .o_imm         (idImm),
        .o_pcPlus4     (idPcPlus4)
    );

    executeStage u_execute (
        .clock          (clock),
        .i_rstN         (i_rstN),
        .i_regWrite     (idRegWrite),
        .i_memToReg     (idMemToReg),
        .i_memWrite     (idMemWrite),
        .i_branch       (idBranch),
        .i_aluSrc       (idAluSrc),
        .i_aluOp        (idAluOp),
        .i_srcA         (idSrcA),
        .i_srcB         (idSrcB),
        .i_rs           (idRs),
        .i_rt           (idRt),
        .i_writeReg     (idWriteReg),
        .i_imm          (idImm),
        .i_pcPlus4      (idPcPlus4),
        .i_branchTaken  (branchTaken),
        .i_memRegWrite  (memRegWrite),
        .i_memWriteReg  (memWriteReg),
        .i_memAluOut    (memAluOut),
        .i_wbWrite      (o_wbValid),
        .i_wbReg        (o_wbReg),
        .i_wbData       (o_wbData),
        .o_regWrite     (exRegWrite),
        .o_memToReg     (exMemToReg),
        .o_memWrite     (exMemWrite),
        .o_branch       (exBranch),
        .o_zero         (exZero),
        .o_aluOut       (exAluOut),
        .o_storeData    (exStoreData),
        .o_writeReg     (exWriteReg),
        .o_branchTarget (exBranchTarget)
    );

    memoryStage u_memory (
        .clock          (clock),
        .i_rstN         (i_rstN),
        .i_regWrite     (exRegWrite),
        .i_memToReg     (exMemToReg),
        .i_memWrite     (exMemWrite),
        .i_branch       (exBranch),
        .i_zero         (exZero),
        .i_aluOut       (exAluOut),
        .i_storeData    (exStoreData),
        .i_writeReg     (exWriteReg),
        .i_branchTarget (exBranchTarget),
        .o_branchTaken  (branchTaken),
        .o_branchTarget (branchTarget),
        .o_memRegWrite  (memRegWrite),
        .o_memWriteReg  (memWriteReg),
        .o_memAluOut    (memAluOut),
        .o_wbWrite      (o_wbValid),
        .o_wbReg        (o_wbReg),
        .o_wbData       (o_wbData),
        .o_storeValid   (o_storeValid),
        .o_storeAddr    (o_storeAddr),
        .o_storeData    (o_storeData)
    );

endmodule

//--- tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*;
();

    localparam int progLen    = 40;
    localparam int numProgs   = 8;
    localparam int cycleLimit = 6 * progLen + 30;

    logic                    clock = 1'b0;
    logic                    rstN;
    logic                    run;
    logic                    imemWe;
    logic [memAddrWidth-1:0] imemAddr;
    logic [dataWidth-1:0]    imemData;
    logic                    wbValid;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;
    logic                    storeValid;
    logic [dataWidth-1:0]    storeAddr;
    logic [dataWidth-1:0]    storeData;

    logic [31:0]             lfsrState;
    logic [31:0]             progWords [progLen];
    logic [dataWidth-1:0]    modelRegs [32];
    logic [dataWidth-1:0]    modelMem [memWords];
    logic [regAddrWidth-1:0] expWbReg [$];
    logic [dataWidth-1:0]    expWbData [$];
    logic [dataWidth-1:0]    expStAddr [$];
    logic [dataWidth-1:0]    expStData [$];
    int                      progIndex;
    int                      runCycles;

    always #10 clock = ~clock;

    cpuTop i_dut (
        .clock        (clock),
        .i_rstN       (rstN),
        .i_run        (run),
        .i_imemWe     (imemWe),
        .i_imemAddr   (imemAddr),
        .i_imemData   (imemData),
        .o_wbValid    (wbValid),
        .o_wbReg      (wbReg),
        .o_wbData     (wbData),
        .o_storeValid (storeValid),
        .o_storeAddr  (storeAddr),
        .o_storeData  (storeData)
    );

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic flagMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
        abortRun();
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++)
            value = {value[30:0], nextBit()};
        return value;
    endfunction

    function automatic logic [5:0] pickFunct(input logic [2:0] sel);
        logic [5:0] fn;
        case (sel)
            3'd0, 3'd5: fn = fnAdd;
            3'd1, 3'd6: fn = fnSub;
            3'd2, 3'd7: fn = fnAnd;
            3'd3:       fn = fnOr;
            default:    fn = fnSlt;
        endcase
        return fn;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic genProgram();
        logic [7:0]              stored;
        logic [2:0]              kind;
        logic [2:0]              word;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] loadRt;
        logic                    afterLoad;
        int                      skipEnd;
        int                      k;
        stored    = '0;
        skipEnd   = -1;
        afterLoad = 1'b0;
        loadRt    = '0;
        for (int p = 0; p < progLen; p++)
        begin
            kind = 3'(randBits(3));
            rs   = 5'(randBits(3));
            rt   = 5'(randBits(3));
            rd   = 5'(randBits(3));
            // Often use a load result right away
            if (afterLoad && randBits(1) != '0)
                rs = loadRt;
            if (afterLoad && randBits(1) != '0)
                rt = loadRt;
            afterLoad = 1'b0;
            // Loads only read words whose store no beq can skip
            if ((kind == 3'd5 || kind == 3'd7) && stored == '0)
                kind = 3'd4;
            case (kind)
                3'd2, 3'd3: progWords[p] = iType(opAddi, rs, rt, 16'(randBits(16)));
                3'd4:
                begin
                    word = 3'(randBits(3));
                    if (p > skipEnd)
                        stored[word] = 1'b1;
                    progWords[p] = iType(opSw, '0, rt, {11'd0, word, 2'b00});
                end
                3'd5, 3'd7:
                begin
                    word = 3'(randBits(3));
                    while (!stored[word])
                        word = word + 3'd1;
                    progWords[p] = iType(opLw, '0, rt, {11'd0, word, 2'b00});
                    afterLoad    = 1'b1;
                    loadRt       = rt;
                end
                3'd6:
                begin
                    // Forward target at most one past the last instruction
                    k = int'(randBits(2));
                    if (k > progLen - 1 - p)
                        k = progLen - 1 - p;
                    if (randBits(1) != '0)
                        rt = rs;
                    skipEnd      = (p + k > skipEnd) ? p + k : skipEnd;
                    progWords[p] = iType(opBeq, rs, rt, 16'(k));
                end
                default: progWords[p] = rType(pickFunct(3'(randBits(3))), rd, rs, rt);
            endcase
        end
    endtask

    task automatic retireWrite(input logic [4:0] dest, input logic [31:0] value);
        if (dest != '0)
        begin
            modelRegs[dest] = value;
            expWbReg.push_back(dest);
            expWbData.push_back(value);
        end
    endtask

    // Instruction-level model that queues every write and store in order
    task automatic runModel();
        instrT                w;
        int                   pc;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] imm;
        logic [dataWidth-1:0] result;
        pc = 0;
        while (pc < progLen)
        begin
            w      = progWords[pc];
            a      = modelRegs[w.r.rs];
            b      = modelRegs[w.r.rt];
            imm    = {{16{w.i.imm[15]}}, w.i.imm};
            result = a + imm;
            pc     = pc + 1;
            case (w.r.opcode)
                opRType:
                begin
                    case (w.r.funct)
                        fnAdd:   result = a + b;
                        fnSub:   result = a - b;
                        fnAnd:   result = a & b;
                        fnOr:    result = a | b;
                        default: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    retireWrite(w.r.rd, result);
                end
                opAddi: retireWrite(w.i.rt, result);
                opLw:   retireWrite(w.i.rt, modelMem[result[7:2]]);
                opSw:
                begin
                    modelMem[result[7:2]] = b;
                    expStAddr.push_back(result);
                    expStData.push_back(b);
                end
                opBeq:
                begin
                    if (a == b)
                        pc = pc + int'($signed(w.i.imm));
                end
                default: ;
            endcase
        end
    endtask

    // Words past the program hold undecoded opcodes tagged with their address
    task automatic loadProgram();
        for (int a = 0; a < memWords; a++)
        begin
            imemWe   = 1'b1;
            imemAddr = 6'(a);
            imemData = (a < progLen) ? progWords[a] : {6'h3f, 20'd0, 6'(a)};
            @(negedge clock);
        end
        imemWe = 1'b0;
    endtask

    // Compare DUT events in order against the model queues
    always @(negedge clock)
    begin
        if (wbValid)
        begin
            assert (expWbReg.size() != 0)
            else
            begin
                $display("Unexpected register write to r%0d", wbReg);
                abortRun();
            end
            if (expWbReg.size() != 0)
            begin
                assert (wbReg == expWbReg[0])
                else flagMismatch("o_wbReg", 32'(wbReg), 32'(expWbReg[0]));
                assert (wbData == expWbData[0])
                else flagMismatch("o_wbData", wbData, expWbData[0]);
                void'(expWbReg.pop_front());
                void'(expWbData.pop_front());
            end
        end
        if (storeValid)
        begin
            assert (expStAddr.size() != 0)
            else
            begin
                $display("Unexpected store to address 0x%08h", storeAddr);
                abortRun();
            end
            if (expStAddr.size() != 0)
            begin
                assert (storeAddr == expStAddr[0])
                else flagMismatch("o_storeAddr", storeAddr, expStAddr[0]);
                assert (storeData == expStData[0])
                else flagMismatch("o_storeData", storeData, expStData[0]);
                void'(expStAddr.pop_front());
                void'(expStData.pop_front());
            end
        end
    end

    // Run length per program
    always @(posedge clock)
    begin
        runCycles = run ? runCycles + 1 : 0;
        if (runCycles > cycleLimit)
        begin
            $display("Timeout in program %0d, events still missing after %0d cycles",
                     progIndex, cycleLimit);
            abortRun();
        end
    end

    initial
    begin
        lfsrState = 32'h3338cafb;
        rstN      = 1'b0;
        run       = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        for (int r = 0; r < 32; r++)
            modelRegs[r] = '0;
        repeat (3) @(negedge clock);
        rstN = 1'b1;
        for (progIndex = 0; progIndex < numProgs; progIndex++)
        begin
            genProgram();
            runModel();
            loadProgram();
            run = 1'b1;
            while (expWbReg.size() != 0 || expStAddr.size() != 0)
                @(posedge clock);
            // Nothing more may come out
            repeat (10) @(negedge clock);
            run = 1'b0;
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- src.f
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
tb/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator and run, the exit status is the simulator's own
cd "$(dirname "$0")" &&
    verilator --binary --assert -j 0 --timescale 1ns/1ps \
        --top-module cpuTb -f src.f &&
    ./obj_dir/VcpuTb ||
    exit 1
